//--- logic/rv_decode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

////////////////////
// Datapath sizes
////////////////////

// Data and instruction width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NUM_REGS 32
`define RV_REG_AW 5

////////////////////
// Field positions
////////////////////

// Source register 1
`define RV_RS1_MSB 19
`define RV_RS1_LSB 15

// Source register 2
`define RV_RS2_MSB 24
`define RV_RS2_LSB 20

// Destination register
`define RV_RD_MSB 11
`define RV_RD_LSB 7

// Sequential PC step, no compressed support
`define RV_PC_INCR 4

`endif

//--- logic/rv_decode_pkg.sv
`include "rv_decode_macros.svh"

package rv_decode_pkg;

  ////////////////////
  // Encodings
  ////////////////////

  // Base RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // Arithmetic ops first, then the branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  ////////////////////
  // Instruction views
  ////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } r_view_t;

  // Store and branch split their immediate around rs1/rs2
  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    opcode_e               opcode;
  } s_view_t;

  typedef union packed {
    r_view_t r_view;
    s_view_t s_view;
  } instr_u;

  ////////////////////
  // Stage interfaces
  ////////////////////

  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    logic      rf_we;
    logic      lsu_req;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sign_ext;
    logic      is_jump;
    logic      is_branch;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e             op;
    logic [`RV_XLEN-1:0] operand_a;
    logic [`RV_XLEN-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic                req;
    logic                we;
    lsu_size_e           size;
    logic                sign_ext;
    logic [`RV_XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                  we;
    logic [`RV_REG_AW-1:0] addr;
    logic [`RV_XLEN-1:0]   data;
  } rf_wr_t;

endpackage

//--- logic/rv_decoder.sv
`timescale 1ns/1ps

`include "rv_decode_macros.svh"

module rv_decoder (
  input  rv_decode_pkg::instr_u    instr_i,
  output rv_decode_pkg::dec_ctrl_t ctrl_o,
  output logic [`RV_XLEN-1:0]      imm_o
);

  logic [6:0]          funct7;
  logic [2:0]          funct3;
  logic [`RV_XLEN-1:0] imm_i_type;
  logic [`RV_XLEN-1:0] imm_s_type;
  logic [`RV_XLEN-1:0] imm_b_type;
  logic [`RV_XLEN-1:0] imm_u_type;
  logic [`RV_XLEN-1:0] imm_j_type;

  assign funct7 = instr_i.r_view.funct7;
  assign funct3 = instr_i.r_view.funct3;

  // Shared by OP and OP-IMM, alt picks SUB or SRA
  function automatic rv_decode_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'b001:  arith_op = rv_decode_pkg::ALU_SLL;
      3'b010:  arith_op = rv_decode_pkg::ALU_SLT;
      3'b011:  arith_op = rv_decode_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_decode_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'b110:  arith_op = rv_decode_pkg::ALU_OR;
      default: arith_op = rv_decode_pkg::ALU_AND;
    endcase
  endfunction

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i_type = {{20{funct7[6]}}, funct7, instr_i.r_view.rs2};
  assign imm_s_type = {{20{instr_i.s_view.imm_hi[6]}}, instr_i.s_view.imm_hi,
                       instr_i.s_view.imm_lo};
  assign imm_b_type = {{19{instr_i.s_view.imm_hi[6]}}, instr_i.s_view.imm_hi[6],
                       instr_i.s_view.imm_lo[0], instr_i.s_view.imm_hi[5:0],
                       instr_i.s_view.imm_lo[4:1], 1'b0};
  assign imm_u_type = {funct7, instr_i.r_view.rs2, instr_i.r_view.rs1, funct3, 12'b0};
  // J format scatters imm[19:12] over rs1 and funct3
  assign imm_j_type = {{12{funct7[6]}}, instr_i.r_view.rs1, funct3, instr_i.r_view.rs2[0],
                       funct7[5:0], instr_i.r_view.rs2[4:1], 1'b0};

  ////////////////////
  // Control decode
  ////////////////////

  always_comb begin
    ctrl_o              = '0;
    ctrl_o.alu_op       = rv_decode_pkg::ALU_ADD;
    ctrl_o.op_a_sel     = rv_decode_pkg::OP_A_REG;
    ctrl_o.op_b_sel     = rv_decode_pkg::OP_B_REG;
    ctrl_o.lsu_size     = rv_decode_pkg::LSU_WORD;
    imm_o               = imm_i_type;

    case (instr_i.r_view.opcode)
      rv_decode_pkg::OPC_OP: begin
        ctrl_o.rf_we   = 1'b1;
        ctrl_o.alu_op  = arith_op(funct3, funct7[5]);
        // Only ADD/SUB and SRL/SRA have a second encoding
        ctrl_o.illegal = !((funct7 == 7'b0000000) ||
                           (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      rv_decode_pkg::OPC_OP_IMM: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl_o.alu_op   = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          ctrl_o.illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          ctrl_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      rv_decode_pkg::OPC_LUI: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = rv_decode_pkg::OP_A_ZERO;
        ctrl_o.op_b_sel = rv_decode_pkg::OP_B_IMM;
        imm_o           = imm_u_type;
      end
      rv_decode_pkg::OPC_AUIPC: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = rv_decode_pkg::OP_A_PC;
        ctrl_o.op_b_sel = rv_decode_pkg::OP_B_IMM;
        imm_o           = imm_u_type;
      end
      rv_decode_pkg::OPC_LOAD: begin
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.lsu_req      = 1'b1;
        ctrl_o.op_b_sel     = rv_decode_pkg::OP_B_IMM;
        ctrl_o.lsu_size     = rv_decode_pkg::lsu_size_e'(funct3[1:0]);
        ctrl_o.lsu_sign_ext = ~funct3[2];
        // LB LH LW LBU LHU
        ctrl_o.illegal      = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      rv_decode_pkg::OPC_STORE: begin
        ctrl_o.lsu_req  = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl_o.lsu_size = rv_decode_pkg::lsu_size_e'(funct3[1:0]);
        ctrl_o.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
        imm_o           = imm_s_type;
      end
      rv_decode_pkg::OPC_BRANCH: begin
        // Compare rs1 with rs2, the target adder sits in fetch
        ctrl_o.is_branch = 1'b1;
        imm_o            = imm_b_type;
        case (funct3)
          3'b000:  ctrl_o.alu_op = rv_decode_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = rv_decode_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = rv_decode_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op = rv_decode_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op = rv_decode_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = rv_decode_pkg::ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      rv_decode_pkg::OPC_JAL: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.is_jump  = 1'b1;
        ctrl_o.op_a_sel = rv_decode_pkg::OP_A_PC;
        ctrl_o.op_b_sel = rv_decode_pkg::OP_B_IMM;
        imm_o           = imm_j_type;
      end
      rv_decode_pkg::OPC_JALR: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.is_jump  = 1'b1;
        ctrl_o.op_a_sel = rv_decode_pkg::OP_A_PC;
        ctrl_o.op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl_o.illegal  = (funct3 != 3'b000);
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Nothing with side effects leaves an illegal instruction
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we     = 1'b0;
      ctrl_o.lsu_req   = 1'b0;
      ctrl_o.lsu_we    = 1'b0;
      ctrl_o.is_jump   = 1'b0;
      ctrl_o.is_branch = 1'b0;
    end
  end

endmodule

//--- logic/rv_register_file.sv
`timescale 1ns/1ps

`include "rv_decode_macros.svh"

module rv_register_file (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`RV_REG_AW-1:0]  raddr_a_i,
  input  logic [`RV_REG_AW-1:0]  raddr_b_i,
  output logic [`RV_XLEN-1:0]    rdata_a_o,
  output logic [`RV_XLEN-1:0]    rdata_b_o,
  input  rv_decode_pkg::rf_wr_t  wr_i
);

  // No storage for x0
  logic [`RV_XLEN-1:0] regs_q [1:`RV_NUM_REGS-1];

  ////////////////////
  // Write port
  ////////////////////

  for (genvar i = 1; i < `RV_NUM_REGS; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[i] <= '0;
      end else if (wr_i.we && (wr_i.addr == `RV_REG_AW'(i))) begin
        regs_q[i] <= wr_i.data;
      end
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    if (raddr_a_i != '0) begin
      rdata_a_o = regs_q[raddr_a_i];
    end
    if (raddr_b_i != '0) begin
      rdata_b_o = regs_q[raddr_b_i];
    end
  end

endmodule

//--- logic/rv_issue_ctrl.sv
`timescale 1ns/1ps

`include "rv_decode_macros.svh"

module rv_issue_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      instr_valid_i,
  input  logic [`RV_XLEN-1:0]       pc_i,
  input  logic [`RV_REG_AW-1:0]     rd_addr_i,
  input  rv_decode_pkg::dec_ctrl_t  ctrl_i,
  input  logic [`RV_XLEN-1:0]       imm_i,
  input  logic [`RV_XLEN-1:0]       rdata_a_i,
  input  logic [`RV_XLEN-1:0]       rdata_b_i,
  input  logic                      ex_ready_i,
  input  logic                      branch_decision_i,
  input  logic [`RV_XLEN-1:0]       ex_result_i,
  input  logic [`RV_XLEN-1:0]       lsu_rdata_i,
  output rv_decode_pkg::alu_req_t   alu_req_o,
  output rv_decode_pkg::lsu_req_t   lsu_req_o,
  output rv_decode_pkg::rf_wr_t     wr_o,
  output logic                      id_ready_o,
  output logic                      id_valid_o,
  output logic                      pc_set_o
);

  typedef enum logic {
    IDLE,
    WAIT
  } id_fsm_e;

  id_fsm_e fsm_q;
  id_fsm_e fsm_d;
  logic    taken_branch;
  logic    multicycle;
  logic    stall;
  logic    rf_we;
  logic    sel_lsu;

  ////////////////////
  // Operands
  ////////////////////

  always_comb begin
    alu_req_o.op = ctrl_i.alu_op;

    case (ctrl_i.op_a_sel)
      rv_decode_pkg::OP_A_REG: alu_req_o.operand_a = rdata_a_i;
      rv_decode_pkg::OP_A_PC:  alu_req_o.operand_a = pc_i;
      default:                 alu_req_o.operand_a = '0;
    endcase

    // Jumps compute the link address pc + 4
    if (ctrl_i.is_jump) begin
      alu_req_o.operand_b = `RV_XLEN'(`RV_PC_INCR);
    end else if (ctrl_i.op_b_sel == rv_decode_pkg::OP_B_IMM) begin
      alu_req_o.operand_b = imm_i;
    end else begin
      alu_req_o.operand_b = rdata_b_i;
    end
  end

  assign lsu_req_o.req      = ctrl_i.lsu_req & instr_valid_i;
  assign lsu_req_o.we       = ctrl_i.lsu_we;
  assign lsu_req_o.size     = ctrl_i.lsu_size;
  assign lsu_req_o.sign_ext = ctrl_i.lsu_sign_ext;
  assign lsu_req_o.wdata    = rdata_b_i;

  ////////////////////
  // Stall FSM
  ////////////////////

  assign taken_branch = ctrl_i.is_branch & branch_decision_i;
  assign multicycle   = ctrl_i.lsu_req | ctrl_i.is_jump | taken_branch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q <= IDLE;
    end else begin
      fsm_q <= fsm_d;
    end
  end

  always_comb begin
    fsm_d    = fsm_q;
    stall    = 1'b0;
    rf_we    = 1'b0;
    sel_lsu  = 1'b0;
    pc_set_o = 1'b0;

    case (fsm_q)
      IDLE: begin
        if (instr_valid_i) begin
          // Redirect fetch as soon as the target is known
          pc_set_o = ctrl_i.is_jump | taken_branch;
          if (multicycle) begin
            stall = 1'b1;
            fsm_d = WAIT;
          end else begin
            rf_we = ctrl_i.rf_we;
          end
        end
      end
      WAIT: begin
        if (ex_ready_i) begin
          rf_we   = ctrl_i.rf_we & instr_valid_i;
          sel_lsu = ctrl_i.lsu_req;
          fsm_d   = IDLE;
        end else begin
          stall = 1'b1;
        end
      end
      default: fsm_d = IDLE;
    endcase
  end

  assign id_ready_o = ~stall;
  assign id_valid_o = instr_valid_i & id_ready_o;

  // Write-back source, loads take the LSU data
  assign wr_o.we   = rf_we;
  assign wr_o.addr = rd_addr_i;
  assign wr_o.data = sel_lsu ? lsu_rdata_i : ex_result_i;

endmodule

//--- logic/rv_id_stage.sv
`timescale 1ns/1ps

`include "rv_decode_macros.svh"

module rv_id_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     instr_valid_i,
  input  logic [`RV_XLEN-1:0]      instr_i,
  input  logic [`RV_XLEN-1:0]      pc_i,
  input  logic                     ex_ready_i,
  input  logic                     branch_decision_i,
  input  logic [`RV_XLEN-1:0]      ex_result_i,
  input  logic [`RV_XLEN-1:0]      lsu_rdata_i,
  output logic                     id_ready_o,
  output logic                     id_valid_o,
  output rv_decode_pkg::alu_req_t  alu_req_o,
  output rv_decode_pkg::lsu_req_t  lsu_req_o,
  output logic                     pc_set_o,
  output logic                     illegal_insn_o
);

  rv_decode_pkg::dec_ctrl_t dec_ctrl;
  logic [`RV_XLEN-1:0]      dec_imm;
  logic [`RV_XLEN-1:0]      rf_rdata_a;
  logic [`RV_XLEN-1:0]      rf_rdata_b;
  rv_decode_pkg::rf_wr_t    rf_wr;

  assign illegal_insn_o = dec_ctrl.illegal;

  rv_decoder i_decoder (
    .instr_i (instr_i),
    .ctrl_o  (dec_ctrl),
    .imm_o   (dec_imm)
  );

  // Reads start from the raw word, in parallel with decode
  rv_register_file i_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (instr_i[`RV_RS1_MSB:`RV_RS1_LSB]),
    .raddr_b_i (instr_i[`RV_RS2_MSB:`RV_RS2_LSB]),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wr_i      (rf_wr)
  );

  rv_issue_ctrl i_issue_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .pc_i              (pc_i),
    .rd_addr_i         (instr_i[`RV_RD_MSB:`RV_RD_LSB]),
    .ctrl_i            (dec_ctrl),
    .imm_i             (dec_imm),
    .rdata_a_i         (rf_rdata_a),
    .rdata_b_i         (rf_rdata_b),
    .ex_ready_i        (ex_ready_i),
    .branch_decision_i (branch_decision_i),
    .ex_result_i       (ex_result_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .alu_req_o         (alu_req_o),
    .lsu_req_o         (lsu_req_o),
    .wr_o              (rf_wr),
    .id_ready_o        (id_ready_o),
    .id_valid_o        (id_valid_o),
    .pc_set_o          (pc_set_o)
  );

endmodule

//--- tb/rv_id_stage_tb.sv
`timescale 1ns/1ps

`include "rv_decode_macros.svh"

module rv_id_stage_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int SEED         = 92;
  localparam int ITERS        = 8;
  localparam int MAX_DELAY    = 6;
  // Twenty instructions per round plus the first ADD after reset
  localparam int N_INSTR      = 1 + ITERS * 20;
  localparam int LIMIT_CYCLES = N_INSTR * (MAX_DELAY + 2) + RESET_CYCLES + 50;

  // Expected response of the stage for the instruction on the bus
  typedef struct packed {
    logic                    ready;
    logic                    pc_set;
    logic                    illegal;
    logic                    chk_ops;
    logic                    chk_op;
    rv_decode_pkg::alu_req_t alu;
    rv_decode_pkg::lsu_req_t lsu;
  } want_t;

  logic                    clk_i             = 1'b0;
  logic                    rst_ni            = 1'b0;
  logic                    instr_valid_i     = 1'b0;
  logic [`RV_XLEN-1:0]     instr_i           = '0;
  logic [`RV_XLEN-1:0]     pc_i              = '0;
  logic                    ex_ready_i        = 1'b0;
  logic                    branch_decision_i = 1'b0;
  logic [`RV_XLEN-1:0]     ex_result_i       = '0;
  logic [`RV_XLEN-1:0]     lsu_rdata_i       = '0;
  logic                    id_ready_o;
  logic                    id_valid_o;
  rv_decode_pkg::alu_req_t alu_req_o;
  rv_decode_pkg::lsu_req_t lsu_req_o;
  logic                    pc_set_o;
  logic                    illegal_insn_o;

  want_t               want;
  logic [`RV_XLEN-1:0] ref_regs [`RV_NUM_REGS];
  int                  errors  = 0;
  int                  n_instr = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  rv_id_stage i_dut (.*);

  ////////////////////
  // Checks
  ////////////////////

  // Sampled at the falling edge half a cycle after the inputs move
  a_ready: assert property (@(negedge clk_i) instr_valid_i |-> id_ready_o == want.ready)
    else begin
      errors++;
      $display("Fail at %0t ns: id_ready_o = %b, expected %b", $time, id_ready_o, want.ready);
    end

  a_valid: assert property (@(negedge clk_i) instr_valid_i |-> id_valid_o == want.ready)
    else begin
      errors++;
      $display("Fail at %0t ns: id_valid_o = %b, expected %b", $time, id_valid_o, want.ready);
    end

  a_idle: assert property (@(negedge clk_i) !instr_valid_i |-> !id_valid_o && !pc_set_o)
    else begin
      errors++;
      $display("Fail at %0t ns: id_valid_o or pc_set_o is high with no valid instruction",
               $time);
    end

  a_pc_set: assert property (@(negedge clk_i) instr_valid_i |-> pc_set_o == want.pc_set)
    else begin
      errors++;
      $display("Fail at %0t ns: pc_set_o = %b, expected %b", $time, pc_set_o, want.pc_set);
    end

  a_illegal: assert property (@(negedge clk_i)
                              instr_valid_i |-> illegal_insn_o == want.illegal)
    else begin
      errors++;
      $display("Fail at %0t ns: illegal_insn_o = %b, expected %b", $time, illegal_insn_o,
               want.illegal);
    end

  a_op_a: assert property (@(negedge clk_i) instr_valid_i && want.chk_ops |->
                           alu_req_o.operand_a == want.alu.operand_a)
    else begin
      errors++;
      $display("Fail at %0t ns: alu_req_o.operand_a = %h, expected %h", $time,
               alu_req_o.operand_a, want.alu.operand_a);
    end

  a_op_b: assert property (@(negedge clk_i) instr_valid_i && want.chk_ops |->
                           alu_req_o.operand_b == want.alu.operand_b)
    else begin
      errors++;
      $display("Fail at %0t ns: alu_req_o.operand_b = %h, expected %h", $time,
               alu_req_o.operand_b, want.alu.operand_b);
    end

  a_alu_op: assert property (@(negedge clk_i) instr_valid_i && want.chk_op |->
                             alu_req_o.op == want.alu.op)
    else begin
      errors++;
      $display("Fail at %0t ns: alu_req_o.op = %0d, expected %0d", $time, alu_req_o.op,
               want.alu.op);
    end

  a_lsu_req: assert property (@(negedge clk_i) instr_valid_i |-> lsu_req_o.req == want.lsu.req)
    else begin
      errors++;
      $display("Fail at %0t ns: lsu_req_o.req = %b, expected %b", $time, lsu_req_o.req,
               want.lsu.req);
    end

  a_lsu_ctrl: assert property (@(negedge clk_i) instr_valid_i && want.lsu.req |->
                               lsu_req_o.we == want.lsu.we && lsu_req_o.size == want.lsu.size &&
                               lsu_req_o.sign_ext == want.lsu.sign_ext)
    else begin
      errors++;
      $display("Fail at %0t ns: lsu_req_o we/size/sign_ext = %b/%0d/%b, expected %b/%0d/%b",
               $time, lsu_req_o.we, lsu_req_o.size, lsu_req_o.sign_ext, want.lsu.we,
               want.lsu.size, want.lsu.sign_ext);
    end

  a_lsu_wdata: assert property (@(negedge clk_i) instr_valid_i && want.lsu.we |->
                                lsu_req_o.wdata == want.lsu.wdata)
    else begin
      errors++;
      $display("Fail at %0t ns: lsu_req_o.wdata = %h, expected %h", $time, lsu_req_o.wdata,
               want.lsu.wdata);
    end

  ////////////////////
  // Encoding helpers
  ////////////////////

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // Access width named by funct3 of a load or store
  function automatic rv_decode_pkg::lsu_size_e access_size(input logic [2:0] f3);
    case (f3[1:0])
      2'b00:   return rv_decode_pkg::LSU_BYTE;
      2'b01:   return rv_decode_pkg::LSU_HALF;
      default: return rv_decode_pkg::LSU_WORD;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  task automatic expect_ops(input logic [31:0] a, input logic [31:0] b, input logic add_op);
    want         = '0;
    want.chk_ops = 1'b1;
    want.chk_op  = add_op;
    want.alu     = '{op: rv_decode_pkg::ALU_ADD, operand_a: a, operand_b: b};
  endtask

  task automatic write_ref(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
      ref_regs[rd] = value;
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Starts on a rising edge and returns on the edge that completes the instruction
  // ex_ready_i rises after delay wait cycles
  task automatic issue(input logic [31:0] instr, input logic [31:0] pc, input logic taken,
                       input logic stalls, input logic redirect, input int delay,
                       output logic [31:0] ex_res, output logic [31:0] ld_data);
    int   waited;
    logic done;
    waited  = 0;
    done    = 1'b0;
    n_instr++;
    ex_res  = $urandom;
    ld_data = $urandom;
    instr_valid_i     <= 1'b1;
    instr_i           <= instr;
    pc_i              <= pc;
    branch_decision_i <= taken;
    ex_ready_i        <= 1'b0;
    ex_result_i       <= ex_res;
    lsu_rdata_i       <= ld_data;
    want.ready  = !stalls;
    want.pc_set = redirect;
    while (!done) begin
      @(negedge clk_i);
      done = id_valid_o;
      @(posedge clk_i);
      if (!done) begin
        waited++;
        ex_res  = $urandom;
        ld_data = $urandom;
        ex_ready_i  <= (waited > delay);
        ex_result_i <= ex_res;
        lsu_rdata_i <= ld_data;
        want.ready  = (waited > delay);
        want.pc_set = 1'b0;
      end
    end
  endtask

  task automatic go_idle(input int cycles);
    instr_valid_i     <= 1'b0;
    branch_decision_i <= 1'b0;
    ex_ready_i        <= 1'b0;
    want = '0;
    repeat (cycles) @(posedge clk_i);
  endtask

  // ADD with rs2 = x0 and rd = x0 exposes a register on operand A
  task automatic read_back(input logic [4:0] rd);
    logic [31:0] ex;
    logic [31:0] ld;
    expect_ops(ref_regs[rd], 32'h0, 1'b1);
    issue(enc_r(7'h00, 5'd0, rd, 3'b000, 5'd0), 32'h0, 1'b0, 1'b0, 1'b0, 0, ex, ld);
  endtask

  task automatic immediate_test();
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] ex;
    logic [31:0] ld;
    r   = $urandom;
    imm = $urandom;
    pc  = {r[31:2], 2'b00};
    expect_ops(ref_regs[r[19:15]], sext12(imm[11:0]), 1'b1);
    issue(enc_i(imm[11:0], r[19:15], 3'b000, r[11:7], 7'h13), pc, 1'b0, 1'b0, 1'b0, 0, ex, ld);
    write_ref(r[11:7], ex);
    // U format puts imm[31:12] over twelve zero bits
    expect_ops(32'h0, {imm[31:12], 12'h000}, 1'b1);
    issue({imm[31:12], r[11:7], 7'h37}, pc, 1'b0, 1'b0, 1'b0, 0, ex, ld);
    write_ref(r[11:7], ex);
    expect_ops(pc, {imm[31:12], 12'h000}, 1'b1);
    issue({imm[31:12], r[11:7], 7'h17}, pc, 1'b0, 1'b0, 1'b0, 0, ex, ld);
    write_ref(r[11:7], ex);
    // JAL hands pc and 4 to the ALU for the link address
    expect_ops(pc, 32'd4, 1'b1);
    issue({imm[20], imm[10:1], imm[11], imm[19:12], r[11:7], 7'h6f}, pc, 1'b0, 1'b1, 1'b1,
          $urandom_range(MAX_DELAY, 0), ex, ld);
    write_ref(r[11:7], ex);
  endtask

  task automatic single_cycle_test();
    logic [31:0] r;
    logic [31:0] imm;
    logic [6:0]  f7;
    logic [31:0] ex;
    logic [31:0] ld;
    r   = $urandom;
    imm = $urandom;
    // Alternate encodings exist only for ADD/SUB and SRL/SRA
    f7  = ((r[14:12] == 3'b000 || r[14:12] == 3'b101) && imm[30]) ? 7'h20 : 7'h00;
    expect_ops(ref_regs[r[19:15]], ref_regs[r[24:20]], 1'b0);
    issue(enc_r(f7, r[24:20], r[19:15], r[14:12], r[11:7]), 32'h0, 1'b0, 1'b0, 1'b0, 0,
          ex, ld);
    write_ref(r[11:7], ex);
    read_back(r[11:7]);
    if (r[14:12] == 3'b001 || r[14:12] == 3'b101) begin
      imm[11:5] = (r[14:12] == 3'b101 && imm[30]) ? 7'h20 : 7'h00;
    end
    expect_ops(ref_regs[r[19:15]], sext12(imm[11:0]), 1'b0);
    issue(enc_i(imm[11:0], r[19:15], r[14:12], r[11:7], 7'h13), 32'h0, 1'b0, 1'b0, 1'b0, 0,
          ex, ld);
    write_ref(r[11:7], ex);
    read_back(r[11:7]);
    read_back(5'd0);
  endtask

  task automatic load_store_test();
    logic [31:0] r;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [31:0] ex;
    logic [31:0] ld;
    r   = $urandom;
    imm = $urandom;
    // Fold the reserved codes onto LB LH LW LBU LHU
    f3  = r[14:12];
    if (f3 == 3'b011) begin
      f3 = 3'b010;
    end else if (f3[2:1] == 2'b11) begin
      f3 = {2'b10, f3[0]};
    end
    expect_ops(ref_regs[r[19:15]], sext12(imm[11:0]), 1'b1);
    want.lsu = '{req: 1'b1, we: 1'b0, size: access_size(f3),
                 sign_ext: !f3[2], wdata: 32'h0};
    issue(enc_i(imm[11:0], r[19:15], f3, r[11:7], 7'h03), 32'h0, 1'b0, 1'b1, 1'b0,
          $urandom_range(MAX_DELAY, 0), ex, ld);
    write_ref(r[11:7], ld);
    read_back(r[11:7]);
    f3 = (r[13:12] == 2'b11) ? 3'b010 : {1'b0, r[13:12]};
    expect_ops(ref_regs[r[19:15]], sext12(imm[11:0]), 1'b1);
    want.lsu = '{req: 1'b1, we: 1'b1, size: access_size(f3),
                 sign_ext: 1'b0, wdata: ref_regs[r[24:20]]};
    issue({imm[11:5], r[24:20], r[19:15], f3, imm[4:0], 7'h23}, 32'h0, 1'b0, 1'b1, 1'b0,
          $urandom_range(MAX_DELAY, 0), ex, ld);
  endtask

  task automatic branch_jump_test();
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [2:0]  f3;
    logic [31:0] ex;
    logic [31:0] ld;
    r   = $urandom;
    imm = $urandom;
    pc  = {imm[31:2], 2'b00};
    f3  = r[14:12];
    // funct3 010 and 011 are reserved for branches
    if (f3[2:1] == 2'b01) begin
      f3[1] = 1'b0;
    end
    instr = {imm[12], imm[10:5], r[24:20], r[19:15], f3, imm[4:1], imm[11], 7'h63};
    expect_ops(ref_regs[r[19:15]], ref_regs[r[24:20]], 1'b0);
    issue(instr, pc, 1'b0, 1'b0, 1'b0, 0, ex, ld);
    expect_ops(ref_regs[r[19:15]], ref_regs[r[24:20]], 1'b0);
    issue(instr, pc, 1'b1, 1'b1, 1'b1, $urandom_range(MAX_DELAY, 0), ex, ld);
    expect_ops(pc, 32'd4, 1'b1);
    issue(enc_i(imm[11:0], r[19:15], 3'b000, r[11:7], 7'h67), pc, 1'b0, 1'b1, 1'b1,
          $urandom_range(MAX_DELAY, 0), ex, ld);
    write_ref(r[11:7], ex);
    read_back(r[11:7]);
  endtask

  task automatic illegal_test();
    logic [31:0] r;
    logic [6:0]  opc;
    logic [31:0] ex;
    logic [31:0] ld;
    r = $urandom;
    case (r[2:0])
      3'd0:    opc = 7'h0b;
      3'd1:    opc = 7'h2b;
      3'd2:    opc = 7'h5b;
      3'd3:    opc = 7'h7b;
      default: opc = 7'h73;
    endcase
    want         = '0;
    want.illegal = 1'b1;
    issue({r[31:7], opc}, 32'h0, 1'b0, 1'b0, 1'b0, 0, ex, ld);
    read_back(r[11:7]);
    // funct7 0000001 belongs to the M extension
    want         = '0;
    want.illegal = 1'b1;
    issue(enc_r(7'h01, r[24:20], r[19:15], r[14:12], r[11:7]), 32'h0, 1'b0, 1'b0, 1'b0, 0,
          ex, ld);
    read_back(r[11:7]);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] ex;
    logic [31:0] ld;
    void'($urandom(SEED));
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    want = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    go_idle(2);
    // Registers come out of reset as zero
    r = $urandom;
    expect_ops(32'h0, 32'h0, 1'b1);
    issue(enc_r(7'h00, r[24:20], r[19:15], 3'b000, r[11:7]), 32'h0, 1'b0, 1'b0, 1'b0, 0,
          ex, ld);
    write_ref(r[11:7], ex);
    repeat (ITERS) begin
      immediate_test();
      single_cycle_test();
      load_store_test();
      branch_jump_test();
      illegal_test();
    end
    go_idle(2);
    $display("Instructions issued: %0d, failed checks: %0d", n_instr, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the stage never completed the sequence",
             LIMIT_CYCLES);
    $display("Instructions issued: %0d, failed checks: %0d", n_instr, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- rv_decode.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/rv_decoder.sv
logic/rv_register_file.sv
logic/rv_issue_ctrl.sv
logic/rv_id_stage.sv
tb/rv_id_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f rv_decode.f \
  --top-module rv_id_stage_tb \
  -o rv_id_stage_sim

./obj_dir/rv_id_stage_sim | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi

echo "Simulation passed"
